/* design/axi_line_params.svh */
// --------------------
// Line master parameters.
// Bus and line geometry shared by all blocks.
// --------------------
`ifndef AXI_LINE_PARAMS_SVH
`define AXI_LINE_PARAMS_SVH

// --------------------
// AXI bus widths.
// --------------------
`define AXI_ADDR_W 64 // Byte address.
`define AXI_DATA_W 32 // One beat.

// --------------------
// Line geometry.
// --------------------
`define LINE_W 512

// Beats per line, LINE_W / AXI_DATA_W.
`define BEATS 16

// Enough bits to index every beat.
`define BEAT_IDX_W 4

`endif

/* design/axi_line_pkg.sv */
// --------------------
// Line master package.
// Line view, FSM states and AXI response codes.
// --------------------
`include "axi_line_params.svh"

package axi_line_pkg;

    // --------------------
    // Line storage.
    // --------------------

    // Flat at the client, beat-indexed on the bus. Beat 0 sits in the low bits.
    typedef union packed {
        logic [ `LINE_W - 1:0 ]                       flat;
        logic [ `BEATS  - 1:0 ][ `AXI_DATA_W - 1:0 ] beats;
    } t_line;

    // --------------------
    // Transaction states.
    // --------------------
    typedef enum logic [1:0] {
        IDLE  = 2'b00, // Waiting for a client start.
        WRITE = 2'b01, // Address, then 16 W beats.
        READ  = 2'b10, // Address, then 16 R beats.
        RESP  = 2'b11  // Waiting for the write response.
    } t_state;

    // --------------------
    // AXI response codes.
    // --------------------
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* design/beat_counter.sv */
// --------------------
// Beat counter.
// Index of the current beat within a line burst, with a last-beat flag.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module beat_counter (
    input  logic                        clk,
    input  logic                        arstn,

    // Control.
    input  logic                        i_clear, // New transaction.
    input  logic                        i_step,  // Accepted beat.

    // Status.
    output logic [ `BEAT_IDX_W - 1:0 ] o_idx,
    output logic                        o_last
);
    localparam logic [ `BEAT_IDX_W - 1:0 ] LAST_IDX = `BEAT_IDX_W'(`BEATS - 1);

    logic [ `BEAT_IDX_W - 1:0 ] s_idx;

    // --------------------
    // Counter.
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            s_idx <= '0;
        end
        else if (i_clear) begin
            s_idx <= '0; // Clear has priority.
        end
        else if (i_step) begin
            s_idx <= s_idx + 1'b1; // Wraps back to zero after the last beat.
        end
    end

    // --------------------
    // Outputs.
    // --------------------
    assign o_idx  = s_idx;
    assign o_last = (s_idx == LAST_IDX);

endmodule

/* design/write_serializer.sv */
// --------------------
// Write serializer.
// Holds the line to be written and presents
// the beat chosen by the counter on W_DATA.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module write_serializer (
    input  logic                        clk,

    // Line capture at acceptance.
    input  logic                        i_load,
    input  axi_line_pkg::t_line         i_data,

    // Current beat.
    input  logic [ `BEAT_IDX_W - 1:0 ] i_idx,
    output logic [ `AXI_DATA_W - 1:0 ] o_w_data
);
    axi_line_pkg::t_line s_line;

    // --------------------
    // Line register.
    // --------------------
    always_ff @(posedge clk) begin
        if (i_load) begin
            s_line <= i_data;
        end
    end

    // --------------------
    // Beat select.
    // --------------------

    // Index moves only on an accepted beat, so the word stays stable while stalled.
    assign o_w_data = s_line.beats[i_idx];

endmodule

/* design/read_deserializer.sv */
// --------------------
// Read deserializer.
// Drops each accepted R beat into its slot of the line register.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module read_deserializer (
    input  logic                        clk,
    input  logic                        arstn,

    // Accepted beat.
    input  logic                        i_capture,
    input  logic [ `BEAT_IDX_W - 1:0 ] i_idx,
    input  logic [ `AXI_DATA_W - 1:0 ] i_r_data,

    // Assembled line, beat 0 in the low bits.
    output axi_line_pkg::t_line         o_line
);

    // --------------------
    // Line assembly.
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            o_line <= '0;
        end
        else if (i_capture) begin
            o_line.beats[i_idx] <= i_r_data; // Other slots keep their value.
        end
    end

endmodule

/* design/burst_fsm.sv */
// --------------------
// Burst FSM.
// Runs one line transfer: address handshake, 16 data beats,
// and for writes the B response. Reports done and a sticky error.
// --------------------
`timescale 1ns/100ps

module burst_fsm (
    input  logic       clk,
    input  logic       arstn,

    // Client requests.
    input  logic       i_start_read,
    input  logic       i_start_write,

    // AXI handshake inputs.
    input  logic       i_ar_ready,
    input  logic       i_aw_ready,
    input  logic       i_w_ready,
    input  logic       i_r_valid,
    input  logic       i_r_last,
    input  logic [1:0] i_r_resp,
    input  logic       i_b_valid,
    input  logic [1:0] i_b_resp,

    // Beat counter.
    input  logic       i_cnt_last,

    output logic       o_ar_valid,
    output logic       o_aw_valid,
    output logic       o_w_valid,
    output logic       o_w_last,
    output logic       o_r_ready,
    output logic       o_b_ready,
    output logic       o_cnt_clear,
    output logic       o_cnt_step,
    output logic       o_load,
    output logic       o_capture,
    output logic       o_busy,
    output logic       o_done,
    output logic       o_resp_err
);
    axi_line_pkg::t_state s_state;
    axi_line_pkg::t_state s_next;

    logic s_ar_valid, s_aw_valid;
    logic s_err, s_done, s_resp_err;
    logic s_accept_rd, s_accept_wr;
    logic s_ar_hs, s_aw_hs, s_w_hs, s_r_hs, s_b_hs;
    logic s_r_err, s_b_err;
    logic s_end;

    // --------------------
    // Handshakes.
    // --------------------
    assign s_accept_rd = (s_state == axi_line_pkg::IDLE) & i_start_read; // Read wins.
    assign s_accept_wr = (s_state == axi_line_pkg::IDLE) & ~i_start_read & i_start_write;

    assign s_ar_hs = s_ar_valid & i_ar_ready;
    assign s_aw_hs = s_aw_valid & i_aw_ready;
    assign s_w_hs  = o_w_valid  & i_w_ready;
    assign s_r_hs  = o_r_ready  & i_r_valid;
    assign s_b_hs  = o_b_ready  & i_b_valid;

    assign s_r_err = s_r_hs & (i_r_resp != axi_line_pkg::RESP_OKAY);
    assign s_b_err = s_b_hs & (i_b_resp != axi_line_pkg::RESP_OKAY);

    // Last R beat or the B response closes the transaction.
    assign s_end = (s_r_hs & i_r_last) | s_b_hs;

    // --------------------
    // Next state.
    // --------------------
    always_comb begin
        s_next = s_state;
        case (s_state)
            axi_line_pkg::IDLE: begin
                if (s_accept_rd) s_next = axi_line_pkg::READ;
                else if (s_accept_wr) s_next = axi_line_pkg::WRITE;
            end
            axi_line_pkg::READ:  if (s_r_hs & i_r_last) s_next = axi_line_pkg::IDLE;
            axi_line_pkg::WRITE: if (s_w_hs & i_cnt_last) s_next = axi_line_pkg::RESP;
            axi_line_pkg::RESP:  if (s_b_hs) s_next = axi_line_pkg::IDLE;
            default: s_next = axi_line_pkg::IDLE;
        endcase
    end

    // --------------------
    // Registers.
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            s_state    <= axi_line_pkg::IDLE;
            s_ar_valid <= 1'b0;
            s_aw_valid <= 1'b0;
            s_err      <= 1'b0;
            s_done     <= 1'b0;
            s_resp_err <= 1'b0;
        end
        else begin
            s_state <= s_next;

            // Address valid held until the slave takes it.
            if (s_accept_rd) s_ar_valid <= 1'b1;
            else if (s_ar_hs) s_ar_valid <= 1'b0;

            if (s_accept_wr) s_aw_valid <= 1'b1;
            else if (s_aw_hs) s_aw_valid <= 1'b0;

            // Sticky R error, fresh for each request.
            if (s_accept_rd | s_accept_wr) s_err <= 1'b0;
            else if (s_r_err) s_err <= 1'b1;

            s_done     <= s_end;
            s_resp_err <= s_end & (s_err | s_r_err | s_b_err);
        end
    end

    // --------------------
    // Outputs.
    // --------------------
    assign o_ar_valid = s_ar_valid;
    assign o_aw_valid = s_aw_valid;
    assign o_w_valid  = (s_state == axi_line_pkg::WRITE) & ~s_aw_valid; // After AW accepted.
    assign o_w_last   = o_w_valid & i_cnt_last;
    assign o_r_ready  = (s_state == axi_line_pkg::READ);
    assign o_b_ready  = (s_state == axi_line_pkg::RESP);

    assign o_cnt_clear = s_accept_rd | s_accept_wr;
    assign o_cnt_step  = s_w_hs | s_r_hs;
    assign o_load      = s_accept_wr;
    assign o_capture   = s_r_hs;

    assign o_busy     = (s_state != axi_line_pkg::IDLE);
    assign o_done     = s_done;
    assign o_resp_err = s_resp_err;

endmodule

/* design/axi_line_master.sv */
// --------------------
// AXI line master.
// Reads or writes one 512-bit line as a 16-beat INCR burst.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module axi_line_master (
    input  logic                            clk,
    input  logic                            arstn,

    // Client.
    input  logic [ `AXI_ADDR_W     - 1:0 ] i_addr,
    input  logic [ `LINE_W         - 1:0 ] i_data,
    input  logic                            i_start_read,
    input  logic                            i_start_write,
    output logic [ `LINE_W         - 1:0 ] o_data,
    output logic                            o_busy,
    output logic                            o_done,
    output logic                            o_resp_err,

    // --------------------
    // AXI write channels.
    // --------------------
    input  logic                            i_aw_ready,
    output logic                            o_aw_valid,
    output logic [ `AXI_ADDR_W     - 1:0 ] o_aw_addr,
    output logic [                    7:0 ] o_aw_len,
    output logic [                    2:0 ] o_aw_size,
    output logic [                    1:0 ] o_aw_burst,
    output logic [                    2:0 ] o_aw_prot,

    input  logic                            i_w_ready,
    output logic                            o_w_valid,
    output logic [ `AXI_DATA_W     - 1:0 ] o_w_data,
    output logic [ `AXI_DATA_W / 8 - 1:0 ] o_w_strb,
    output logic                            o_w_last,

    input  logic                            i_b_valid,
    input  logic [                    1:0 ] i_b_resp,
    output logic                            o_b_ready,

    // --------------------
    // AXI read channels.
    // --------------------
    input  logic                            i_ar_ready,
    output logic                            o_ar_valid,
    output logic [ `AXI_ADDR_W     - 1:0 ] o_ar_addr,
    output logic [                    7:0 ] o_ar_len,
    output logic [                    2:0 ] o_ar_size,
    output logic [                    1:0 ] o_ar_burst,
    output logic [                    2:0 ] o_ar_prot,

    input  logic                            i_r_valid,
    input  logic [ `AXI_DATA_W     - 1:0 ] i_r_data,
    input  logic [                    1:0 ] i_r_resp,
    input  logic                            i_r_last,
    output logic                            o_r_ready
);
    logic                        s_cnt_clear, s_cnt_step;
    logic [ `BEAT_IDX_W - 1:0 ] s_idx;
    logic                        s_last;
    logic                        s_load, s_capture;
    logic [ `AXI_ADDR_W - 1:0 ] s_addr;
    axi_line_pkg::t_line         s_rd_line;

    // Request address, taken when the counter is cleared at acceptance.
    always_ff @(posedge clk) begin
        if (s_cnt_clear) s_addr <= i_addr;
    end

    // --------------------
    // Fixed burst fields.
    // --------------------
    assign o_aw_addr  = s_addr;
    assign o_aw_len   = 8'(`BEATS - 1); // 16 beats.
    assign o_aw_size  = 3'b010;         // 4 bytes per beat.
    assign o_aw_burst = 2'b01;          // INCR.
    assign o_aw_prot  = 3'b010;         // Unprivileged, non-secure, data.
    assign o_w_strb   = '1;

    assign o_ar_addr  = s_addr;
    assign o_ar_len   = 8'(`BEATS - 1);
    assign o_ar_size  = 3'b010;
    assign o_ar_burst = 2'b01;
    assign o_ar_prot  = 3'b010;

    assign o_data = s_rd_line.flat;

    // --------------------
    // Blocks.
    // --------------------
    burst_fsm burst_fsm_inst (
        .clk           (clk),
        .arstn         (arstn),
        .i_start_read  (i_start_read),
        .i_start_write (i_start_write),
        .i_ar_ready    (i_ar_ready),
        .i_aw_ready    (i_aw_ready),
        .i_w_ready     (i_w_ready),
        .i_r_valid     (i_r_valid),
        .i_r_last      (i_r_last),
        .i_r_resp      (i_r_resp),
        .i_b_valid     (i_b_valid),
        .i_b_resp      (i_b_resp),
        .i_cnt_last    (s_last),
        .o_ar_valid    (o_ar_valid),
        .o_aw_valid    (o_aw_valid),
        .o_w_valid     (o_w_valid),
        .o_w_last      (o_w_last),
        .o_r_ready     (o_r_ready),
        .o_b_ready     (o_b_ready),
        .o_cnt_clear   (s_cnt_clear),
        .o_cnt_step    (s_cnt_step),
        .o_load        (s_load),
        .o_capture     (s_capture),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_resp_err    (o_resp_err)
    );

    beat_counter beat_counter_inst (
        .clk     (clk),
        .arstn   (arstn),
        .i_clear (s_cnt_clear),
        .i_step  (s_cnt_step),
        .o_idx   (s_idx),
        .o_last  (s_last)
    );

    write_serializer write_serializer_inst (
        .clk      (clk),
        .i_load   (s_load),
        .i_data   (i_data),
        .i_idx    (s_idx),
        .o_w_data (o_w_data)
    );

    read_deserializer read_deserializer_inst (
        .clk       (clk),
        .arstn     (arstn),
        .i_capture (s_capture),
        .i_idx     (s_idx),
        .i_r_data  (i_r_data),
        .o_line    (s_rd_line)
    );

endmodule

/* tb/axi_line_props.sv */
// --------------------
// AXI line master protocol assertions.
// Bound into the burst FSM.
// --------------------
`timescale 1ns/100ps

module axi_line_props (
    input logic                 clk,
    input logic                 arstn,
    input logic                 i_ar_valid,
    input logic                 i_ar_ready,
    input logic                 i_aw_valid,
    input logic                 i_aw_ready,
    input logic                 i_w_valid,
    input logic                 i_w_ready,
    input logic                 i_w_last,
    input logic                 i_done,
    input axi_line_pkg::t_state i_state
);
    // Address valid held until the handshake.
    a_ar_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_ar_valid && !i_ar_ready |=> i_ar_valid)
        else $error("AR_VALID dropped before AR_READY");

    a_aw_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_aw_valid && !i_aw_ready |=> i_aw_valid)
        else $error("AW_VALID dropped before AW_READY");

    // W beat and its payload stay put while stalled.
    a_w_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w_last))
        else $error("W beat changed before W_READY");

    a_w_last: assert property (@(posedge clk) disable iff (!arstn)
        i_w_last |-> i_w_valid)
        else $error("W_LAST without W_VALID");

    // Read address only pending inside its own burst.
    a_ar_state: assert property (@(posedge clk) disable iff (!arstn)
        i_ar_valid |-> i_state == axi_line_pkg::READ)
        else $error("AR_VALID outside the READ state");

    a_done_pulse: assert property (@(posedge clk) disable iff (!arstn)
        i_done |=> !i_done)
        else $error("done held longer than one cycle");

endmodule

/* tb/axi_line_checker.sv */
// --------------------
// AXI line master checker.
// Counts handshakes per transaction and compares results at done.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module axi_line_checker (
    input  logic                        clk,
    input  logic                        arstn,
    input  logic                        i_start,
    input  logic                        i_aw_valid,
    input  logic                        i_aw_ready,
    input  logic [ `AXI_ADDR_W - 1:0 ] i_aw_addr,
    input  logic [                7:0 ] i_aw_len,
    input  logic [                2:0 ] i_aw_size,
    input  logic [                1:0 ] i_aw_burst,
    input  logic [                2:0 ] i_aw_prot,
    input  logic                        i_ar_valid,
    input  logic                        i_ar_ready,
    input  logic [ `AXI_ADDR_W - 1:0 ] i_ar_addr,
    input  logic [                7:0 ] i_ar_len,
    input  logic [                2:0 ] i_ar_size,
    input  logic [                1:0 ] i_ar_burst,
    input  logic [                2:0 ] i_ar_prot,
    input  logic                        i_w_valid,
    input  logic                        i_w_ready,
    input  logic                        i_w_last,
    input  logic [                3:0 ] i_w_strb,
    input  logic                        i_r_valid,
    input  logic                        i_r_ready,
    input  logic                        i_b_ready,
    input  logic                        i_busy,
    input  logic                        i_done,
    input  logic                        i_resp_err,
    input  logic [ `LINE_W     - 1:0 ] i_data,
    // Expectations for the running test.
    input  logic                        i_exp_write,
    input  logic [ `AXI_ADDR_W - 1:0 ] i_exp_addr,
    input  logic [ `LINE_W     - 1:0 ] i_exp_data,
    input  logic                        i_exp_err,
    input  int                          i_test_id,
    output int                          o_tests,
    output int                          o_errors
);
    int s_w_beats, s_r_beats, s_addr_hs;
    bit s_started, s_bad;

    task automatic report_error(input string msg);
        $display("error at %0t: test %0d: %s", $time, i_test_id, msg);
        o_errors++;
        s_bad = 1'b1;
    endtask

    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_tests   = 0;
            o_errors  = 0;
            s_started = 1'b0;
        end
        else begin
            // Idle outputs until the first request.
            if (!s_started && (i_aw_valid | i_ar_valid | i_w_valid | i_w_last | i_r_ready |
                               i_b_ready | i_busy | i_done | i_resp_err))
                report_error("outputs not idle after reset");
            if (i_start && !i_busy) begin
                s_started = 1'b1;
                s_bad     = 1'b0;
                s_w_beats = 0;
                s_r_beats = 0;
                s_addr_hs = 0;
            end

            // --------------------
            // Handshake counting.
            // --------------------

            // Size 2 is 4-byte beats, burst 1 is INCR, prot 010 is unprivileged non-secure data.
            if (i_aw_valid && i_aw_ready) begin
                s_addr_hs++;
                if (!i_exp_write || i_aw_addr != i_exp_addr || i_aw_len != 8'd15)
                    report_error("wrong AW address or length");
                if (i_aw_size != 3'd2 || i_aw_burst != 2'b01 || i_aw_prot != 3'b010)
                    report_error("wrong AW size, burst type or protection");
            end
            if (i_ar_valid && i_ar_ready) begin
                s_addr_hs++;
                if (i_exp_write || i_ar_addr != i_exp_addr || i_ar_len != 8'd15)
                    report_error("wrong AR address or length");
                if (i_ar_size != 3'd2 || i_ar_burst != 2'b01 || i_ar_prot != 3'b010)
                    report_error("wrong AR size, burst type or protection");
            end
            if (i_w_valid && i_w_ready) begin
                s_w_beats++;
                if (i_w_last != (s_w_beats == `BEATS))
                    report_error("W_LAST on the wrong beat");
                if (i_w_strb != 4'hf)
                    report_error("W_STRB is not all ones");
            end
            if (i_r_valid && i_r_ready)
                s_r_beats++;

            // --------------------
            // End of transaction.
            // --------------------
            if (i_done) begin
                if (s_addr_hs != 1)
                    report_error("address handshake count is not one");
                if (i_exp_write && s_w_beats != `BEATS)
                    report_error($sformatf("%0d W beats instead of 16", s_w_beats));
                if (!i_exp_write && s_r_beats != `BEATS)
                    report_error($sformatf("%0d R beats instead of 16", s_r_beats));
                if (i_resp_err != i_exp_err)
                    report_error($sformatf("resp_err %0b, expected %0b", i_resp_err, i_exp_err));
                if (!i_exp_write && i_data != i_exp_data)
                    report_error($sformatf("read data %h, expected %h", i_data, i_exp_data));
                $display("test %0d %s %s", i_test_id, i_exp_write ? "write" : "read",
                         s_bad ? "failed" : "passed");
                o_tests++;
            end
        end
    end

endmodule

/* tb/tb_axi_line_master.sv */
// --------------------
// AXI line master testbench.
// Golden-file tests against a behavioural AXI memory with random stalls.
// --------------------
`timescale 1ns/100ps
`include "axi_line_params.svh"

module tb_axi_line_master;
    localparam int MAX_TESTS = 32;

    logic                        clk, arstn;
    logic [ `AXI_ADDR_W - 1:0 ] addr, aw_addr, ar_addr;
    logic [ `LINE_W     - 1:0 ] wr_line, rd_line;
    logic                        start_read, start_write, busy, done, resp_err;
    logic [7:0]                  aw_len, ar_len;
    logic [2:0]                  aw_size, ar_size, aw_prot, ar_prot;
    logic [1:0]                  aw_burst, ar_burst, b_resp, r_resp;
    logic [ `AXI_DATA_W - 1:0 ] w_data, r_data;
    logic [3:0]                  w_strb;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last;

    // Expectations shown to the checker.
    logic                        exp_write, exp_err;
    logic [ `AXI_ADDR_W - 1:0 ] exp_addr;
    logic [ `LINE_W     - 1:0 ] exp_data;
    int                          test_id, chk_tests, chk_errors;

    // Golden table.
    bit                          g_write [MAX_TESTS];
    logic [ `AXI_ADDR_W - 1:0 ] g_addr  [MAX_TESTS];
    logic [31:0]                 g_pat   [MAX_TESTS];
    logic [31:0]                 g_exp   [MAX_TESTS];
    int                          g_inj   [MAX_TESTS];
    bit                          g_err   [MAX_TESTS];
    int                          n_tests = 0;

    integer seed;
    logic [ `LINE_W - 1:0 ] mem [logic [ `AXI_ADDR_W - 1:0 ]];

    axi_line_master axi_line_master_inst (
        .clk(clk), .arstn(arstn),
        .i_addr(addr), .i_data(wr_line), .i_start_read(start_read),
        .i_start_write(start_write), .o_data(rd_line), .o_busy(busy),
        .o_done(done), .o_resp_err(resp_err),
        .i_aw_ready(aw_ready), .o_aw_valid(aw_valid), .o_aw_addr(aw_addr),
        .o_aw_len(aw_len), .o_aw_size(aw_size), .o_aw_burst(aw_burst),
        .o_aw_prot(aw_prot), .i_w_ready(w_ready), .o_w_valid(w_valid),
        .o_w_data(w_data), .o_w_strb(w_strb), .o_w_last(w_last),
        .i_b_valid(b_valid), .i_b_resp(b_resp), .o_b_ready(b_ready),
        .i_ar_ready(ar_ready), .o_ar_valid(ar_valid), .o_ar_addr(ar_addr),
        .o_ar_len(ar_len), .o_ar_size(ar_size), .o_ar_burst(ar_burst),
        .o_ar_prot(ar_prot), .i_r_valid(r_valid), .i_r_data(r_data),
        .i_r_resp(r_resp), .i_r_last(r_last), .o_r_ready(r_ready)
    );

    axi_line_checker checker_inst (
        .clk(clk), .arstn(arstn), .i_start(start_read | start_write),
        .i_aw_valid(aw_valid), .i_aw_ready(aw_ready), .i_aw_addr(aw_addr),
        .i_aw_len(aw_len), .i_aw_size(aw_size), .i_aw_burst(aw_burst),
        .i_aw_prot(aw_prot), .i_ar_valid(ar_valid), .i_ar_ready(ar_ready),
        .i_ar_addr(ar_addr), .i_ar_len(ar_len), .i_ar_size(ar_size),
        .i_ar_burst(ar_burst), .i_ar_prot(ar_prot), .i_w_valid(w_valid),
        .i_w_ready(w_ready), .i_w_last(w_last), .i_w_strb(w_strb), .i_r_valid(r_valid),
        .i_r_ready(r_ready), .i_b_ready(b_ready), .i_busy(busy), .i_done(done),
        .i_resp_err(resp_err), .i_data(rd_line), .i_exp_write(exp_write),
        .i_exp_addr(exp_addr), .i_exp_data(exp_data), .i_exp_err(exp_err),
        .i_test_id(test_id), .o_tests(chk_tests), .o_errors(chk_errors)
    );

    bind burst_fsm axi_line_props props_inst (
        .clk(clk), .arstn(arstn), .i_ar_valid(o_ar_valid), .i_ar_ready(i_ar_ready),
        .i_aw_valid(o_aw_valid), .i_aw_ready(i_aw_ready), .i_w_valid(o_w_valid),
        .i_w_ready(i_w_ready), .i_w_last(o_w_last), .i_done(o_done), .i_state(s_state)
    );

    // Beat i of a line is pattern + i * 01010101, beat 0 low.
    function automatic logic [ `LINE_W - 1:0 ] expand_pattern(input logic [31:0] pat);
        axi_line_pkg::t_line line;
        for (int i = 0; i < `BEATS; i++) line.beats[i] = pat + i * 32'h01010101;
        return line.flat;
    endfunction

    // Unwritten lines hold a pattern folded from the whole address.
    function automatic logic [ `LINE_W - 1:0 ] fill_line(input logic [63:0] a);
        return expand_pattern(a[31:0] ^ a[63:32]);
    endfunction

    function automatic logic coin();
        return ($random(seed) & 3) != 0; // Ready or valid three times in four.
    endfunction

    // --------------------
    // AXI memory model.
    // --------------------
    task automatic take_address(input bit is_write, output logic [63:0] a);
        bit hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            if (is_write) aw_ready = coin();
            else ar_ready = coin();
            @(posedge clk);
            hs = is_write ? (aw_valid & aw_ready) : (ar_valid & ar_ready);
            a  = is_write ? aw_addr : ar_addr;
        end
    endtask

    task automatic serve_write(input int inj);
        axi_line_pkg::t_line line;
        logic [63:0] a;
        int k = 0;
        bit hs = 1'b0;
        take_address(1'b1, a);
        while (k < `BEATS) begin
            @(negedge clk);
            aw_ready = 1'b0;
            w_ready  = coin();
            @(posedge clk);
            if (w_valid && w_ready) begin
                line.beats[k] = w_data;
                k++;
            end
        end
        while (!hs) begin
            @(negedge clk);
            w_ready = 1'b0;
            if (!b_valid) b_valid = coin();
            b_resp = (inj == 1) ? axi_line_pkg::RESP_SLVERR : axi_line_pkg::RESP_OKAY;
            @(posedge clk);
            hs = b_valid & b_ready;
        end
        mem[a] = line.flat; // Stored even when SLVERR is returned.
        @(negedge clk);
        b_valid = 1'b0;
    endtask

    task automatic serve_read(input int inj);
        axi_line_pkg::t_line line;
        logic [63:0] a;
        int k = 0;
        bit taken = 1'b0;
        take_address(1'b0, a);
        line.flat = mem.exists(a) ? mem[a] : fill_line(a);
        while (k < `BEATS) begin
            @(negedge clk);
            ar_ready = 1'b0;
            if (taken || !r_valid) r_valid = coin(); // Hold valid until taken.
            taken  = 1'b0;
            r_data = line.beats[k];
            r_last = (k == `BEATS - 1);
            r_resp = (inj == 2 && k == 5) ? axi_line_pkg::RESP_SLVERR : axi_line_pkg::RESP_OKAY;
            @(posedge clk);
            if (r_valid && r_ready) begin
                k++;
                taken = 1'b1;
            end
        end
        @(negedge clk);
        r_valid = 1'b0;
        r_last  = 1'b0;
        r_resp  = axi_line_pkg::RESP_OKAY;
    endtask

    task automatic read_golden();
        int fd, cnt, inj, er;
        string text, op;
        logic [63:0] a;
        logic [31:0] p, e;
        fd = $fopen("tb/axi_line_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            $display("Test failed");
            $finish;
        end
        else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                text = "";
                cnt  = $fgets(text, fd);
                if (cnt > 0 && text.len() > 1 && text[0] != "#") begin
                    cnt = $sscanf(text, "%s %h %h %d %h %d", op, a, p, inj, e, er);
                    if (cnt == 6) begin
                        g_write[n_tests] = (op == "wr");
                        g_addr[n_tests]  = a;
                        g_pat[n_tests]   = p;
                        g_inj[n_tests]   = inj;
                        g_exp[n_tests]   = e;
                        g_err[n_tests]   = (er != 0);
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // Clock, watchdog, main flow.
    // --------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        wait (n_tests > 0);
        #(n_tests * 200 * 4);
        $display("timeout: the DUT did not finish all transactions in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'hc0ccc557;
        arstn = 1'b0;
        {start_read, start_write, aw_ready, w_ready, b_valid, ar_ready} = '0;
        {r_valid, r_last, addr, wr_line, r_data} = '0;
        b_resp = axi_line_pkg::RESP_OKAY;
        r_resp = axi_line_pkg::RESP_OKAY;
        {exp_write, exp_err, exp_addr, exp_data} = '0;
        test_id = 0;
        read_golden();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        repeat (2) @(negedge clk);
        for (int t = 0; t < n_tests; t++) begin
            @(negedge clk);
            test_id     = t + 1;
            exp_write   = g_write[t];
            exp_addr    = g_addr[t];
            exp_data    = expand_pattern(g_exp[t]);
            exp_err     = g_err[t];
            addr        = g_addr[t];
            wr_line     = expand_pattern(g_pat[t]);
            start_write = g_write[t];
            start_read  = !g_write[t];
            @(negedge clk);
            start_write = 1'b0;
            start_read  = 1'b0;
            if (g_write[t]) serve_write(g_inj[t]);
            else serve_read(g_inj[t]);
            do @(posedge clk); while (!done);
        end
        repeat (2) @(posedge clk);
        $display("tests checked: %0d of %0d, errors: %0d", chk_tests, n_tests, chk_errors);
        if (n_tests > 0 && chk_errors == 0 && chk_tests == n_tests) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/axi_line_golden.txt */
# op addr wr_pattern inject exp_pattern exp_err, beat i = pattern + i * 01010101
# inject 0 none, 1 SLVERR on B, 2 SLVERR on R beat 5; unwritten lines hold addr[31:0]^addr[63:32]
wr 0000000000001000 a5a50000 0 00000000 0
rd 0000000000001000 00000000 0 a5a50000 0
rd 0000000000002000 00000000 0 00002000 0
wr 0000000000003040 12345678 1 00000000 1
rd 0000000000003040 00000000 0 12345678 0
rd 0000000000004000 00000000 2 00004000 1
wr 0000000000005000 deadbeef 0 00000000 0
rd 0000000000005000 00000000 0 deadbeef 0
rd ffff000000008000 00000000 0 ffff8000 0
rd 0000000000006000 00000000 2 00006000 1
wr 0000000000006000 0badf00d 0 00000000 0
rd 0000000000006000 00000000 0 0badf00d 0

/* sources.f */
+incdir+design
design/axi_line_pkg.sv
design/beat_counter.sv
design/write_serializer.sv
design/read_deserializer.sv
design/burst_fsm.sv
design/axi_line_master.sv
tb/axi_line_props.sv
tb/axi_line_checker.sv
tb/tb_axi_line_master.sv

/* Bender.yml */
package:
  name: axi_line_master

sources:
  - include_dirs:
      - design
    files:
      - design/axi_line_pkg.sv
      - design/beat_counter.sv
      - design/write_serializer.sv
      - design/read_deserializer.sv
      - design/burst_fsm.sv
      - design/axi_line_master.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/axi_line_props.sv
      - tb/axi_line_checker.sv
      - tb/tb_axi_line_master.sv
